//--- build.f
hdl/dcache_cfg_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_read_arbiter.sv
hdl/dcache_bank_ctrl.sv
hdl/dcache_data_banks.sv
hdl/dcache_tag_array.sv
hdl/dcache_mem_top.sv
test/tb_dcache_mem.sv

//--- hdl/dcache_bank_ctrl.sv
// dcache bank controller, maps refill, granted read and word write onto the data banks
`timescale 1ns/1ps
`default_nettype none

module dcache_bank_ctrl (
  input  logic                                                  rd_gnt_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]                      rd_idx_i,
  input  logic [dcache_cfg_pkg::OFF_W-1:0]                      rd_off_i,
  input  logic                                                  wr_cl_vld_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                   wr_cl_we_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]                      wr_cl_idx_i,
  input  logic [dcache_cfg_pkg::LINE_W-1:0]                     wr_cl_data_i,
  input  logic [dcache_cfg_pkg::LINE_BYTES-1:0]                 wr_cl_data_be_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                   wr_req_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]                      wr_idx_i,
  input  logic [dcache_cfg_pkg::OFF_W-1:0]                      wr_off_i,
  input  logic [dcache_cfg_pkg::WORD_W-1:0]                     wr_data_i,
  input  logic [dcache_cfg_pkg::WORD_BYTES-1:0]                 wr_data_be_i,
  output logic                                                  wr_ack_o,
  output dcache_ctrl_pkg::bank_op_e [dcache_cfg_pkg::NUM_BANKS-1:0] bank_op_o,
  output logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::IDX_W-1:0] bank_idx_o,
  output logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::NUM_WAYS-1:0]
               [dcache_cfg_pkg::WORD_BYTES-1:0]                 bank_be_o,
  output logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::WORD_W-1:0] bank_wdata_o,
  output logic                                                  lookup_o,
  output logic [dcache_cfg_pkg::IDX_W-1:0]                      lookup_idx_o
);

  import dcache_cfg_pkg::*;
  import dcache_ctrl_pkg::*;

  logic [BANK_SEL_W-1:0] rd_bank;
  logic [BANK_SEL_W-1:0] wr_bank;
  logic [NUM_BANKS-1:0]  rd_bank_oh;
  logic [NUM_BANKS-1:0]  wr_bank_oh;

  assign rd_bank    = bank_of(rd_off_i);
  assign wr_bank    = bank_of(wr_off_i);
  assign rd_bank_oh = rd_gnt_i ? bank_onehot(rd_bank) : '0;
  assign wr_bank_oh = bank_onehot(wr_bank);

  // word write only gets through on a free bank
  assign wr_ack_o = (|wr_req_i) && !wr_cl_vld_i && !(rd_gnt_i && (rd_bank == wr_bank));

  // tag lookup runs with every granted read
  assign lookup_o     = rd_gnt_i && !wr_cl_vld_i;
  assign lookup_idx_o = rd_idx_i;

  ////////////////////////////////////////
  // per-bank operation select
  ////////////////////////////////////////

  always_comb begin : p_bank_sel
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_op_o[k]    = BANK_IDLE;
      bank_idx_o[k]   = wr_idx_i;
      bank_be_o[k]    = '0;
      bank_wdata_o[k] = wr_data_i;
      if (wr_cl_vld_i) begin
        // refill owns every bank for this cycle
        bank_op_o[k]    = BANK_REFILL;
        bank_idx_o[k]   = wr_cl_idx_i;
        bank_wdata_o[k] = wr_cl_data_i[k*WORD_W +: WORD_W];
        for (int w = 0; w < NUM_WAYS; w++) begin
          bank_be_o[k][w] = wr_cl_we_i[w] ? wr_cl_data_be_i[k*WORD_BYTES +: WORD_BYTES] : '0;
        end
      end else if (rd_bank_oh[k]) begin
        bank_op_o[k]  = BANK_READ;
        bank_idx_o[k] = rd_idx_i;
      end else if (wr_ack_o && wr_bank_oh[k]) begin
        bank_op_o[k] = BANK_WORD_WRITE;
        // way select comes from the one-hot request
        for (int w = 0; w < NUM_WAYS; w++) begin
          bank_be_o[k][w] = wr_req_i[w] ? wr_data_be_i : '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_cfg_pkg.sv
// cache geometry and address split helpers, imported by every dcache block and the testbench
`default_nettype none

package dcache_cfg_pkg;

  localparam int unsigned NUM_WAYS   = 2;
  localparam int unsigned WAY_IDX_W  = 1;
  localparam int unsigned TAG_W      = 20;
  localparam int unsigned IDX_W      = 4;
  localparam int unsigned NUM_SETS   = 16;
  localparam int unsigned OFF_W      = 5;
  localparam int unsigned BYTE_OFF_W = 3;
  localparam int unsigned WORD_W     = 64;
  localparam int unsigned WORD_BYTES = 8;
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_SEL_W = 2;
  localparam int unsigned LINE_W     = 256;
  localparam int unsigned LINE_BYTES = 32;

  // word offset within the line picks the bank
  function automatic logic [BANK_SEL_W-1:0] bank_of(input logic [OFF_W-1:0] off);
    return off[OFF_W-1:BYTE_OFF_W];
  endfunction

  function automatic logic [NUM_BANKS-1:0] bank_onehot(input logic [BANK_SEL_W-1:0] bank);
    logic [NUM_BANKS-1:0] oh;
    oh       = '0;
    oh[bank] = 1'b1;
    return oh;
  endfunction

endpackage

`default_nettype wire

//--- hdl/dcache_ctrl_pkg.sv
// per-bank operation codes shared by the dcache bank controller and the data banks
`default_nettype none

package dcache_ctrl_pkg;

  ////////////////////////////////////////
  // bank operations
  ////////////////////////////////////////

  // one operation per bank and cycle
  typedef enum logic [1:0] {
    // bank not accessed
    BANK_IDLE,
    // full line write from the refill port
    BANK_REFILL,
    // all ways read for a granted lookup
    BANK_READ,
    // single word store into one way
    BANK_WORD_WRITE
  } bank_op_e;

endpackage

`default_nettype wire

//--- hdl/dcache_data_banks.sv
// dcache data storage, one SRAM bank per line word with registered way-select readout
`timescale 1ns/1ps
`default_nettype none

module dcache_data_banks (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  dcache_ctrl_pkg::bank_op_e [dcache_cfg_pkg::NUM_BANKS-1:0] bank_op_i,
  input  logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::IDX_W-1:0] bank_idx_i,
  input  logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::NUM_WAYS-1:0]
               [dcache_cfg_pkg::WORD_BYTES-1:0]                 bank_be_i,
  input  logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::WORD_W-1:0] bank_wdata_i,
  input  logic [dcache_cfg_pkg::OFF_W-1:0]                      rd_off_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                   rd_hit_oh_i,
  output logic [dcache_cfg_pkg::WORD_W-1:0]                     rd_data_o
);

  import dcache_cfg_pkg::*;
  import dcache_ctrl_pkg::*;

  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_W-1:0] bank_rdata;
  logic [BANK_SEL_W-1:0]                          bank_sel_q;

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    logic [NUM_WAYS-1:0][WORD_W-1:0] mem [NUM_SETS];
    logic [NUM_WAYS-1:0][WORD_W-1:0] rdata_q;

    // all ways of the set are read together
    always_ff @(posedge clk_i) begin : p_sram
      if (bank_op_i[k] == BANK_READ) begin
        rdata_q <= mem[bank_idx_i[k]];
      end else if (bank_op_i[k] == BANK_REFILL || bank_op_i[k] == BANK_WORD_WRITE) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (bank_be_i[k][w][b]) begin
              mem[bank_idx_i[k]][w][b*8 +: 8] <= bank_wdata_i[k][b*8 +: 8];
            end
          end
        end
      end
    end

    assign bank_rdata[k] = rdata_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_bank_sel
    if (!rst_ni) begin
      bank_sel_q <= '0;
    end else begin
      bank_sel_q <= bank_of(rd_off_i);
    end
  end

  // zero when no way hits
  always_comb begin : p_way_mux
    rd_data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rd_hit_oh_i[w]) begin
        rd_data_o = rd_data_o | bank_rdata[bank_sel_q][w];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_mem_top.sv
// top of the dcache memory block, arbiter and bank controller in front of data banks and tags
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_top #(
  parameter int unsigned NUM_PORTS = 3
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // read ports
  input  logic [NUM_PORTS-1:0]                                 rd_req_i,
  input  logic [NUM_PORTS-1:0]                                 rd_prio_i,
  input  logic [NUM_PORTS-1:0][dcache_cfg_pkg::IDX_W-1:0]      rd_idx_i,
  input  logic [NUM_PORTS-1:0][dcache_cfg_pkg::OFF_W-1:0]      rd_off_i,
  input  logic [NUM_PORTS-1:0][dcache_cfg_pkg::TAG_W-1:0]      rd_tag_i,
  output logic [NUM_PORTS-1:0]                                 rd_ack_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                  rd_hit_oh_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                  rd_vld_bits_o,
  output logic [dcache_cfg_pkg::WORD_W-1:0]                    rd_data_o,
  // line refill, port 0 only
  input  logic                                                 wr_cl_vld_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                  wr_cl_we_i,
  input  logic [dcache_cfg_pkg::TAG_W-1:0]                     wr_cl_tag_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]                     wr_cl_idx_i,
  input  logic [dcache_cfg_pkg::LINE_W-1:0]                    wr_cl_data_i,
  input  logic [dcache_cfg_pkg::LINE_BYTES-1:0]                wr_cl_data_be_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                  wr_vld_bits_i,
  // single word write
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0]                  wr_req_i,
  output logic                                                 wr_ack_o,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]                     wr_idx_i,
  input  logic [dcache_cfg_pkg::OFF_W-1:0]                     wr_off_i,
  input  logic [dcache_cfg_pkg::WORD_W-1:0]                    wr_data_i,
  input  logic [dcache_cfg_pkg::WORD_BYTES-1:0]                wr_data_be_i
);

  import dcache_cfg_pkg::*;
  import dcache_ctrl_pkg::*;

  localparam int unsigned PORT_W = $clog2(NUM_PORTS);

  logic [PORT_W-1:0]                          gnt_idx;
  logic [PORT_W-1:0]                          gnt_idx_q;
  logic                                       gnt_vld;
  logic [IDX_W-1:0]                           rd_idx_gnt;
  logic [OFF_W-1:0]                           rd_off_gnt;
  logic [TAG_W-1:0]                           rd_tag_gnt;
  bank_op_e [NUM_BANKS-1:0]                   bank_op;
  logic [NUM_BANKS-1:0][IDX_W-1:0]            bank_idx;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_BYTES-1:0] bank_be;
  logic [NUM_BANKS-1:0][WORD_W-1:0]           bank_wdata;
  logic                                       lookup;
  logic [IDX_W-1:0]                           lookup_idx;

  // address of the winning port
  assign rd_idx_gnt = rd_idx_i[gnt_idx];
  assign rd_off_gnt = rd_off_i[gnt_idx];

  // tag follows one cycle behind, so the port number is kept
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_gnt_idx
    if (!rst_ni) begin
      gnt_idx_q <= '0;
    end else begin
      gnt_idx_q <= gnt_idx;
    end
  end

  assign rd_tag_gnt = rd_tag_i[gnt_idx_q];

  dcache_read_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) i_read_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (rd_req_i),
    .prio_i    (rd_prio_i),
    .block_i   (wr_cl_vld_i),
    .gnt_o     (rd_ack_o),
    .gnt_idx_o (gnt_idx),
    .gnt_vld_o (gnt_vld)
  );

  dcache_bank_ctrl i_bank_ctrl (
    .rd_gnt_i        (gnt_vld),
    .rd_idx_i        (rd_idx_gnt),
    .rd_off_i        (rd_off_gnt),
    .wr_cl_vld_i     (wr_cl_vld_i),
    .wr_cl_we_i      (wr_cl_we_i),
    .wr_cl_idx_i     (wr_cl_idx_i),
    .wr_cl_data_i    (wr_cl_data_i),
    .wr_cl_data_be_i (wr_cl_data_be_i),
    .wr_req_i        (wr_req_i),
    .wr_idx_i        (wr_idx_i),
    .wr_off_i        (wr_off_i),
    .wr_data_i       (wr_data_i),
    .wr_data_be_i    (wr_data_be_i),
    .wr_ack_o        (wr_ack_o),
    .bank_op_o       (bank_op),
    .bank_idx_o      (bank_idx),
    .bank_be_o       (bank_be),
    .bank_wdata_o    (bank_wdata),
    .lookup_o        (lookup),
    .lookup_idx_o    (lookup_idx)
  );

  dcache_data_banks i_data_banks (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_op_i    (bank_op),
    .bank_idx_i   (bank_idx),
    .bank_be_i    (bank_be),
    .bank_wdata_i (bank_wdata),
    .rd_off_i     (rd_off_gnt),
    .rd_hit_oh_i  (rd_hit_oh_o),
    .rd_data_o    (rd_data_o)
  );

  dcache_tag_array i_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .lookup_idx_i  (lookup_idx),
    .rd_tag_i      (rd_tag_gnt),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_read_arbiter.sv
// read port arbiter of the dcache memory, priority masking followed by a round-robin pick
`timescale 1ns/1ps
`default_nettype none

module dcache_read_arbiter #(
  parameter int unsigned NUM_PORTS = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [NUM_PORTS-1:0]         req_i,
  input  logic [NUM_PORTS-1:0]         prio_i,
  input  logic                         block_i,
  output logic [NUM_PORTS-1:0]         gnt_o,
  output logic [$clog2(NUM_PORTS)-1:0] gnt_idx_o,
  output logic                         gnt_vld_o
);

  localparam int unsigned PORT_W = $clog2(NUM_PORTS);

  logic [NUM_PORTS-1:0] req_hi;
  logic [NUM_PORTS-1:0] req_comp;
  logic [PORT_W-1:0]    rr_ptr_q;

  // high priority requests hide all low priority ones
  assign req_hi   = req_i & prio_i;
  assign req_comp = (|req_hi) ? req_hi : req_i;

  // first competing port at or after the pointer, with wrap-around
  always_comb begin : p_pick
    int unsigned pos;
    gnt_o     = '0;
    gnt_idx_o = '0;
    gnt_vld_o = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      pos = (rr_ptr_q + i) % NUM_PORTS;
      if (!gnt_vld_o && req_comp[pos] && !block_i) begin
        gnt_vld_o   = 1'b1;
        gnt_idx_o   = PORT_W'(pos);
        gnt_o[pos]  = 1'b1;
      end
    end
  end

  // pointer moves past the winner, holds while blocked
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (gnt_vld_o) begin
      if (gnt_idx_o == PORT_W'(NUM_PORTS - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= gnt_idx_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_tag_array.sv
// dcache tag and valid store per way, compares the late tag and produces the one-hot hit vector
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                lookup_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]    lookup_idx_i,
  input  logic [dcache_cfg_pkg::TAG_W-1:0]    rd_tag_i,
  input  logic                                wr_cl_vld_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0] wr_cl_we_i,
  input  logic [dcache_cfg_pkg::IDX_W-1:0]    wr_cl_idx_i,
  input  logic [dcache_cfg_pkg::TAG_W-1:0]    wr_cl_tag_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0] wr_vld_bits_i,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0] rd_hit_oh_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0] rd_vld_bits_o
);

  import dcache_cfg_pkg::*;

  logic [NUM_WAYS-1:0][TAG_W-1:0]  tag_mem [NUM_SETS];
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  logic [NUM_WAYS-1:0][TAG_W-1:0]  tag_rdata_q;
  logic [NUM_WAYS-1:0]             vld_rdata_q;
  logic                            cmp_en_q;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_tag_sram
    if (lookup_i) begin
      tag_rdata_q <= tag_mem[lookup_idx_i];
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_cl_vld_i && wr_cl_we_i[w]) begin
        tag_mem[wr_cl_idx_i][w] <= wr_cl_tag_i;
      end
    end
  end

  // valid bits start cleared, so nothing hits before a refill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q     <= '0;
      vld_rdata_q <= '0;
      cmp_en_q    <= 1'b0;
    end else begin
      cmp_en_q <= lookup_i;
      if (lookup_i) begin
        vld_rdata_q <= valid_q[lookup_idx_i];
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_cl_vld_i && wr_cl_we_i[w]) begin
          valid_q[wr_cl_idx_i][w] <= wr_vld_bits_i[w];
        end
      end
    end
  end

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////

  // tag of the granted port arrives one cycle after the index
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = cmp_en_q && vld_rdata_q[w] && (tag_rdata_q[w] == rd_tag_i);
  end

  assign rd_vld_bits_o = vld_rdata_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dcache memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_dcache_mem \
  -Mdir "$BUILD_DIR" -o tb_dcache_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_dcache_mem" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0

//--- test/tb_dcache_mem.sv
// random-stimulus testbench for the dcache memory block that checks every cycle against a model
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_mem;

  import dcache_cfg_pkg::*;

  localparam int NUM_PORTS   = 3;
  localparam int PORT_W      = $clog2(NUM_PORTS);
  localparam int CLK_PERIOD  = 4;
  localparam logic [15:0] SEED = 16'd22;
  localparam int N_REFILL    = 40;
  localparam int N_READ      = 60;
  localparam int N_MERGE     = 30;
  localparam int N_ARB       = 200;
  localparam int N_COLL      = 40;
  localparam int MAX_RETRY   = 16;
  localparam int CYC_PER_TXN = 4;
  localparam int N_TXN       = 2 * NUM_SETS + N_REFILL + N_READ + N_MERGE + N_ARB + N_COLL;
  localparam int WATCHDOG_NS = 2 * N_TXN * CYC_PER_TXN * CLK_PERIOD;

  logic                            clk_i;
  logic                            rst_ni;
  logic [NUM_PORTS-1:0]            rd_req;
  logic [NUM_PORTS-1:0]            rd_prio;
  logic [NUM_PORTS-1:0][IDX_W-1:0] rd_idx;
  logic [NUM_PORTS-1:0][OFF_W-1:0] rd_off;
  logic [NUM_PORTS-1:0][TAG_W-1:0] rd_tag;
  logic [NUM_PORTS-1:0]            rd_ack;
  logic [NUM_WAYS-1:0]             rd_hit_oh;
  logic [NUM_WAYS-1:0]             rd_vld_bits;
  logic [WORD_W-1:0]               rd_data;
  logic                            cl_vld;
  logic [NUM_WAYS-1:0]             cl_we;
  logic [TAG_W-1:0]                cl_tag;
  logic [IDX_W-1:0]                cl_idx;
  logic [LINE_W-1:0]               cl_data;
  logic [LINE_BYTES-1:0]           cl_be;
  logic [NUM_WAYS-1:0]             cl_vld_bits;
  logic [NUM_WAYS-1:0]             wr_req;
  logic                            wr_ack;
  logic [IDX_W-1:0]                wr_idx;
  logic [OFF_W-1:0]                wr_off;
  logic [WORD_W-1:0]               wr_data;
  logic [WORD_BYTES-1:0]           wr_be;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  logic [TAG_W-1:0]    m_tag  [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] m_vld  [NUM_SETS];
  logic [WORD_W-1:0]   m_data [NUM_SETS][NUM_WAYS][NUM_BANKS];
  int                  m_ptr;

  // read granted last cycle and now in its compare cycle
  logic                pend_vld;
  int                  pend_port;
  logic [TAG_W-1:0]    pend_tag;
  logic [NUM_WAYS-1:0] pend_hit;
  logic [NUM_WAYS-1:0] pend_vbits;
  logic [WORD_W-1:0]   pend_data;
  int                  hit_way;

  logic [15:0] lfsr;
  logic        wr_ack_seen;
  int          err_test;
  int          err_total;
  int          test_cnt;
  int          test_fail;

  dcache_mem_top #(
    .NUM_PORTS (NUM_PORTS)
  ) dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rd_req_i        (rd_req),
    .rd_prio_i       (rd_prio),
    .rd_idx_i        (rd_idx),
    .rd_off_i        (rd_off),
    .rd_tag_i        (rd_tag),
    .rd_ack_o        (rd_ack),
    .rd_hit_oh_o     (rd_hit_oh),
    .rd_vld_bits_o   (rd_vld_bits),
    .rd_data_o       (rd_data),
    .wr_cl_vld_i     (cl_vld),
    .wr_cl_we_i      (cl_we),
    .wr_cl_tag_i     (cl_tag),
    .wr_cl_idx_i     (cl_idx),
    .wr_cl_data_i    (cl_data),
    .wr_cl_data_be_i (cl_be),
    .wr_vld_bits_i   (cl_vld_bits),
    .wr_req_i        (wr_req),
    .wr_ack_o        (wr_ack),
    .wr_idx_i        (wr_idx),
    .wr_off_i        (wr_off),
    .wr_data_i       (wr_data),
    .wr_data_be_i    (wr_be)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : p_watchdog
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // masked round-robin choice or -1 when nothing is granted
  function automatic int model_grant();
    logic [NUM_PORTS-1:0] comp;
    int p;
    if (cl_vld) begin
      return -1;
    end
    comp = ((rd_req & rd_prio) != '0) ? (rd_req & rd_prio) : rd_req;
    for (int i = 0; i < NUM_PORTS; i++) begin
      p = (m_ptr + i) % NUM_PORTS;
      if (comp[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic report_mismatch(input string name, input logic [WORD_W-1:0] exp,
                                 input logic [WORD_W-1:0] act);
    $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t ns", name, exp, act, $time);
    err_test++;
  endtask

  task automatic init_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_vld[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w] = '0;
        for (int k = 0; k < NUM_BANKS; k++) begin
          m_data[s][w][k] = '0;
        end
      end
    end
    m_ptr    = 0;
    pend_vld = 1'b0;
    hit_way  = -1;
  endtask

  ////////////////////////////////////////
  // cycle framing
  ////////////////////////////////////////

  // inputs go idle and the pending read gets its tag
  task automatic begin_cycle();
    @(posedge clk_i);
    #1;
    rd_req  = '0;
    rd_prio = '0;
    cl_vld  = 1'b0;
    cl_we   = '0;
    wr_req  = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_tag[p] = TAG_W'(rand_bits(TAG_W));
    end
    if (pend_vld) begin
      rd_tag[pend_port] = pend_tag;
    end
  endtask

  // expected results of a read granted this cycle as seen before this cycle's writes land
  task automatic grant_read(input int port);
    logic [IDX_W-1:0]      idx;
    logic [BANK_SEL_W-1:0] bank;
    int                    way;
    idx  = rd_idx[port];
    bank = rd_off[port][OFF_W-1:BYTE_OFF_W];
    way  = hit_way;
    if (way < 0 && rand_bits(1) != 64'd0) begin
      way = int'(rand_bits(WAY_IDX_W));
    end
    pend_tag   = (way >= 0) ? m_tag[idx][way] : TAG_W'(rand_bits(TAG_W));
    pend_port  = port;
    pend_vld   = 1'b1;
    pend_vbits = m_vld[idx];
    pend_hit   = '0;
    pend_data  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_vld[idx][w] && m_tag[idx][w] == pend_tag) begin
        pend_hit[w] = 1'b1;
        pend_data   = pend_data | m_data[idx][w][bank];
      end
    end
  endtask

  task automatic model_refill();
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (cl_we[w]) begin
        m_tag[cl_idx][w] = cl_tag;
        m_vld[cl_idx][w] = cl_vld_bits[w];
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (cl_be[b]) begin
            m_data[cl_idx][w][b / WORD_BYTES][(b % WORD_BYTES) * 8 +: 8] = cl_data[b * 8 +: 8];
          end
        end
      end
    end
  endtask

  task automatic model_word_write();
    logic [BANK_SEL_W-1:0] bank;
    bank = wr_off[OFF_W-1:BYTE_OFF_W];
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (wr_req[w] && wr_be[b]) begin
          m_data[wr_idx][w][bank][b * 8 +: 8] = wr_data[b * 8 +: 8];
        end
      end
    end
  endtask

  // sample outputs mid cycle and then advance the model past the coming edge
  task automatic end_cycle();
    int                    g;
    logic [NUM_PORTS-1:0]  exp_gnt;
    logic                  exp_wack;
    logic [BANK_SEL_W-1:0] rbank;
    logic [BANK_SEL_W-1:0] wbank;
    #2;
    g       = model_grant();
    exp_gnt = '0;
    rbank   = '0;
    wbank   = wr_off[OFF_W-1:BYTE_OFF_W];
    if (g >= 0) begin
      exp_gnt[g] = 1'b1;
      rbank      = rd_off[g][OFF_W-1:BYTE_OFF_W];
    end
    exp_wack = (wr_req != '0) && !cl_vld && !(g >= 0 && rbank == wbank);
    if (rd_ack !== exp_gnt) begin
      report_mismatch("rd_ack_o", WORD_W'(exp_gnt), WORD_W'(rd_ack));
    end
    if (wr_ack !== exp_wack) begin
      report_mismatch("wr_ack_o", WORD_W'(exp_wack), WORD_W'(wr_ack));
    end
    if (pend_vld) begin
      if (rd_hit_oh !== pend_hit) begin
        report_mismatch("rd_hit_oh_o", WORD_W'(pend_hit), WORD_W'(rd_hit_oh));
      end
      if (rd_vld_bits !== pend_vbits) begin
        report_mismatch("rd_vld_bits_o", WORD_W'(pend_vbits), WORD_W'(rd_vld_bits));
      end
      if (rd_data !== pend_data) begin
        report_mismatch("rd_data_o", pend_data, rd_data);
      end
    end else if (rd_hit_oh !== '0) begin
      report_mismatch("rd_hit_oh_o", '0, WORD_W'(rd_hit_oh));
    end
    wr_ack_seen = wr_ack;
    pend_vld    = 1'b0;
    if (g >= 0) begin
      grant_read(g);
      m_ptr = (g + 1) % NUM_PORTS;
    end
    if (cl_vld) begin
      model_refill();
    end
    if (exp_wack) begin
      model_word_write();
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic drive_read(input int port, input logic [IDX_W-1:0] idx,
                            input logic [OFF_W-1:0] off);
    rd_req[port] = 1'b1;
    rd_idx[port] = idx;
    rd_off[port] = off;
  endtask

  task automatic drive_random_read();
    drive_read(int'(rand_bits(PORT_W)) % NUM_PORTS, IDX_W'(rand_bits(IDX_W)),
               OFF_W'(rand_bits(OFF_W)));
  endtask

  task automatic drive_refill(input logic [IDX_W-1:0] idx, input logic full);
    cl_vld      = 1'b1;
    cl_idx      = idx;
    cl_tag      = TAG_W'(rand_bits(TAG_W));
    cl_we       = full ? '1 : NUM_WAYS'(rand_bits(NUM_WAYS));
    cl_vld_bits = NUM_WAYS'(rand_bits(NUM_WAYS));
    cl_be       = full ? '1 : LINE_BYTES'(rand_bits(LINE_BYTES));
    for (int k = 0; k < NUM_BANKS; k++) begin
      cl_data[k * WORD_W +: WORD_W] = rand_bits(WORD_W);
    end
  endtask

  // holds the write until acked while random reads and refills may compete for the banks
  task automatic write_until_ack(input logic with_reads);
    logic [NUM_WAYS-1:0]   way_oh;
    logic [IDX_W-1:0]      idx;
    logic [OFF_W-1:0]      off;
    logic [WORD_W-1:0]     data;
    logic [WORD_BYTES-1:0] be;
    int                    tries;
    way_oh = '0;
    way_oh[int'(rand_bits(WAY_IDX_W))] = 1'b1;
    idx    = IDX_W'(rand_bits(IDX_W));
    off    = OFF_W'(rand_bits(OFF_W));
    data   = rand_bits(WORD_W);
    be     = WORD_BYTES'(rand_bits(WORD_BYTES));
    tries  = 0;
    do begin
      begin_cycle();
      wr_req  = way_oh;
      wr_idx  = idx;
      wr_off  = off;
      wr_data = data;
      wr_be   = be;
      if (with_reads && rand_bits(2) != 64'd0) begin
        drive_random_read();
      end
      // a refill takes every bank and must hold the write back
      if (with_reads && rand_bits(3) == 64'd0) begin
        drive_refill(IDX_W'(rand_bits(IDX_W)), 1'b0);
      end
      end_cycle();
      tries++;
    end while (!wr_ack_seen && tries < MAX_RETRY);
    if (!wr_ack_seen) begin
      $display("word write to set %0d was never acknowledged", idx);
      err_test++;
    end
  endtask

  task automatic flush_read();
    begin_cycle();
    end_cycle();
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_test != 0) begin
      test_fail++;
    end
    err_total += err_test;
    $display("%s: %s, %0d errors", name, (err_test == 0) ? "ok" : "failed", err_test);
    err_test = 0;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    flush_read();
    for (int s = 0; s < NUM_SETS; s++) begin
      begin_cycle();
      drive_read(0, IDX_W'(s), OFF_W'(rand_bits(OFF_W)));
      end_cycle();
    end
    flush_read();
    finish_test("reset");
  endtask

  task automatic test_refill_hit();
    // every set gets a full line first so no byte stays unwritten
    for (int s = 0; s < NUM_SETS; s++) begin
      begin_cycle();
      drive_refill(IDX_W'(s), 1'b1);
      end_cycle();
    end
    for (int i = 0; i < N_REFILL; i++) begin
      begin_cycle();
      drive_refill(IDX_W'(rand_bits(IDX_W)), 1'b0);
      end_cycle();
    end
    for (int i = 0; i < N_READ; i++) begin
      begin_cycle();
      drive_random_read();
      end_cycle();
    end
    flush_read();
    finish_test("refill and hit");
  endtask

  task automatic test_word_merge();
    for (int i = 0; i < N_MERGE; i++) begin
      write_until_ack(1'b0);
      // read back the written word with the tag of the written way
      hit_way = (wr_req[1]) ? 1 : 0;
      begin_cycle();
      drive_read(int'(rand_bits(PORT_W)) % NUM_PORTS, wr_idx, wr_off);
      end_cycle();
      hit_way = -1;
    end
    flush_read();
    finish_test("word write merge");
  endtask

  task automatic test_arbitration();
    for (int i = 0; i < N_ARB; i++) begin
      begin_cycle();
      rd_req  = NUM_PORTS'(rand_bits(NUM_PORTS));
      rd_prio = NUM_PORTS'(rand_bits(NUM_PORTS));
      for (int p = 0; p < NUM_PORTS; p++) begin
        rd_idx[p] = IDX_W'(rand_bits(IDX_W));
        rd_off[p] = OFF_W'(rand_bits(OFF_W));
      end
      if (rand_bits(2) == 64'd0) begin
        drive_refill(IDX_W'(rand_bits(IDX_W)), 1'b0);
      end
      end_cycle();
    end
    flush_read();
    finish_test("arbitration");
  endtask

  task automatic test_collision();
    for (int i = 0; i < N_COLL; i++) begin
      write_until_ack(1'b1);
    end
    flush_read();
    finish_test("bank collision");
  endtask

  initial begin : p_main
    rst_ni      = 1'b0;
    rd_req      = '0;
    rd_prio     = '0;
    rd_idx      = '0;
    rd_off      = '0;
    rd_tag      = '0;
    cl_vld      = 1'b0;
    cl_we       = '0;
    cl_tag      = '0;
    cl_idx      = '0;
    cl_data     = '0;
    cl_be       = '0;
    cl_vld_bits = '0;
    wr_req      = '0;
    wr_idx      = '0;
    wr_off      = '0;
    wr_data     = '0;
    wr_be       = '0;
    lfsr        = SEED;
    wr_ack_seen = 1'b0;
    err_test    = 0;
    err_total   = 0;
    test_cnt    = 0;
    test_fail   = 0;
    init_model();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_refill_hit();
    test_word_merge();
    test_arbitration();
    test_collision();
    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_total);
    if (err_total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
